// ==== design/banked_memory.sv ====
`timescale 1ns/1ps

module banked_memory import cache_pkg::*; (
	input logic    clk,
	input logic    arst_n,
	mem_if.memory  mif
);

	logic [BEAT_W-1:0] sel;
	logic [ADDR_W-OFFSET_W-1:0] row;

	// Stage one holds every bank's word, stage two the selected one
	logic [DATA_W-1:0] bank_q [WORDS_PER_LINE];
	logic [BEAT_W-1:0] sel_q;
	logic [DATA_W-1:0] out_q;
	logic [MEM_LAT-1:0] vld_pipe;

	// Word offset picks the bank, the rest of the address the row
	assign sel = mif.addr[OFFSET_W-1:1];
	assign row = mif.addr[ADDR_W-1:OFFSET_W];

	for (genvar b = 0; b < WORDS_PER_LINE; b++)
	begin : g_bank
		logic [DATA_W-1:0] mem [MEM_WORDS / WORDS_PER_LINE] = '{default: '0};

		always_ff @(posedge clk)
		begin
			if (mif.wr && sel == BEAT_W'(b))
				mem[row] <= mif.data_in;
			if (mif.rd)
				bank_q[b] <= mem[row];
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[MEM_LAT-2:0], mif.rd};
	end

	always_ff @(posedge clk)
	begin
		if (mif.rd)
			sel_q <= sel;
		out_q <= bank_q[sel_q];
	end

	// Zero when no read is completing
	assign mif.data_out = vld_pipe[MEM_LAT-1] ? out_q : '0;

endmodule

// ==== design/cache_array.sv ====
`timescale 1ns/1ps

module cache_array import cache_pkg::*; (
	input logic   clk,
	input logic   arst_n,
	cache_if.array cif
);

	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;
	logic [TAG_W-1:0] tag_mem [LINES];
	logic [DATA_W-1:0] data_mem [LINES][WORDS_PER_LINE];

	logic [BEAT_W-1:0] word;
	logic tag_match;
	logic fill_wr;
	logic cmp_wr;

	assign word = cif.offset[OFFSET_W-1:1];
	assign tag_match = (tag_mem[cif.index] == cif.tag);

	// Fill overwrites the line; compare write needs a valid matching line
	assign fill_wr = cif.enable && cif.wr && !cif.cmp;
	assign cmp_wr = cif.enable && cif.wr && cif.cmp && tag_match && valid_q[cif.index];

	// Combinational lookup
	assign cif.hit = cif.enable && cif.cmp && tag_match;
	assign cif.valid = valid_q[cif.index];
	assign cif.dirty = dirty_q[cif.index];
	assign cif.tag_out = tag_mem[cif.index];
	assign cif.data_out = data_mem[cif.index][word];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (fill_wr)
		begin
			valid_q[cif.index] <= cif.valid_in;
			dirty_q[cif.index] <= 1'b0;
		end
		else if (cmp_wr)
		begin
			dirty_q[cif.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_wr || cmp_wr)
			data_mem[cif.index][word] <= cif.data_in;
		if (fill_wr)
			tag_mem[cif.index] <= cif.tag;
	end

endmodule

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] data_in,
	input  logic              rd,
	input  logic              wr,
	output logic [DATA_W-1:0] data_out,
	output logic              done,
	output logic              cache_hit,
	output logic              stall,
	cache_if.controller       cif,
	mem_if.controller         mif
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic [INDEX_W-1:0] req_index;
	logic [TAG_W-1:0] req_tag;
	logic [OFFSET_W-1:0] req_offset;
	logic [ADDR_W-OFFSET_W-1:0] line_addr;

	logic [BEAT_W-1:0] wb_beat;
	logic [BEAT_W-1:0] rd_beat;
	logic [BEAT_W-1:0] fill_beat;
	logic fill_rd;
	logic fill_wr;

	// Request fields held stable by the host while stalled
	assign req_index = addr[ADDR_W-1:ADDR_W-INDEX_W];
	assign req_tag = addr[OFFSET_W+TAG_W-1:OFFSET_W];
	assign req_offset = addr[OFFSET_W-1:0];
	assign line_addr = addr[ADDR_W-1:OFFSET_W];

	// Beat numbers within the write-back and fill sequences
	assign wb_beat = BEAT_W'(state - wb_0);
	assign rd_beat = BEAT_W'(state - fill_0);
	assign fill_beat = BEAT_W'(state - fill_2);

	// Memory reads lead array writes by MEM_LAT states
	assign fill_rd = state inside {fill_0, fill_1, fill_2, fill_3};
	assign fill_wr = state inside {fill_2, fill_3, fill_4, fill_5};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;

		cif.enable = 1'b0;
		cif.cmp = 1'b0;
		cif.wr = 1'b0;
		cif.index = req_index;
		cif.offset = req_offset;
		cif.tag = req_tag;
		cif.data_in = data_in;
		cif.valid_in = 1'b0;

		mif.addr = '0;
		mif.data_in = '0;
		mif.wr = 1'b0;
		mif.rd = 1'b0;

		data_out = '0;
		done = 1'b0;
		cache_hit = 1'b0;
		stall = 1'b1;

		// Fill reads of one word per cycle
		if (fill_rd)
		begin
			mif.rd = 1'b1;
			mif.addr = {line_addr, rd_beat, 1'b0};
		end

		// Fill writes from returned memory data
		if (fill_wr)
		begin
			cif.enable = 1'b1;
			cif.wr = 1'b1;
			cif.valid_in = 1'b1;
			cif.offset = {fill_beat, 1'b0};
			cif.data_in = mif.data_out;
		end

		unique case (state)
			idle:
			begin
				stall = 1'b0;
				if (rd)
					next_state = cmp_rd_0;
				else if (wr)
					next_state = cmp_wt_0;
			end

			cmp_rd_0, cmp_wt_0:
			begin
				cif.enable = 1'b1;
				cif.cmp = 1'b1;
				cif.wr = (state == cmp_wt_0);
				if (cif.hit && cif.valid)
					next_state = hit;
				else if (cif.valid && cif.dirty)
					next_state = wb_0;
				else
					next_state = fill_0;
			end

			hit:
			begin
				cif.enable = 1'b1;
				data_out = cif.data_out;
				done = 1'b1;
				cache_hit = 1'b1;
				next_state = idle;
			end

			// Victim address rebuilt from the stored tag
			wb_0, wb_1, wb_2, wb_3:
			begin
				cif.enable = 1'b1;
				cif.offset = {wb_beat, 1'b0};
				mif.addr = {req_index, cif.tag_out, wb_beat, 1'b0};
				mif.data_in = cif.data_out;
				mif.wr = 1'b1;
				next_state = state.next();
			end

			fill_0, fill_1, fill_2, fill_3, fill_4:
				next_state = state.next();

			fill_5:
			begin
				if (rd)
					next_state = cmp_rd_1;
				else if (wr)
					next_state = cmp_wt_1;
				else
					next_state = idle;
			end

			cmp_rd_1:
			begin
				cif.enable = 1'b1;
				cif.cmp = 1'b1;
				data_out = cif.data_out;
				done = 1'b1;
				next_state = idle;
			end

			cmp_wt_1:
			begin
				cif.enable = 1'b1;
				cif.cmp = 1'b1;
				cif.wr = 1'b1;
				done = 1'b1;
				next_state = idle;
			end
		endcase
	end

endmodule

// ==== design/cache_if.sv ====
`timescale 1ns/1ps

// Controller to cache array
interface cache_if import cache_pkg::*; ();
	logic enable;
	logic cmp;
	logic wr;
	logic [INDEX_W-1:0] index;
	logic [OFFSET_W-1:0] offset;
	logic [TAG_W-1:0] tag;
	logic [DATA_W-1:0] data_in;
	logic valid_in;

	logic hit;
	logic dirty;
	logic valid;
	logic [TAG_W-1:0] tag_out;
	logic [DATA_W-1:0] data_out;

	modport controller (
		output enable, cmp, wr, index, offset, tag, data_in, valid_in,
		input hit, dirty, valid, tag_out, data_out
	);

	modport array (
		input enable, cmp, wr, index, offset, tag, data_in, valid_in,
		output hit, dirty, valid, tag_out, data_out
	);
endinterface

// Controller to banked memory
interface mem_if import cache_pkg::*; ();
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data_in;
	logic [DATA_W-1:0] data_out;
	logic wr;
	logic rd;

	modport controller (output addr, data_in, wr, rd, input data_out);
	modport memory (input addr, data_in, wr, rd, output data_out);
endinterface

// ==== design/cache_pkg.sv ====
package cache_pkg;

	// Host address split
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;
	localparam int INDEX_W = 8;
	localparam int TAG_W = 5;
	localparam int OFFSET_W = 3;

	// Cache geometry
	localparam int LINES = 256;
	localparam int WORDS_PER_LINE = 4;
	localparam int BEAT_W = $clog2(WORDS_PER_LINE);

	// Backing memory
	localparam int MEM_WORDS = 32768;
	localparam int MEM_LAT = 2;

	// Controller states in the order the miss path walks them
	typedef enum logic [3:0] {
		idle     = 4'd0,
		hit      = 4'd1,
		cmp_rd_0 = 4'd2,
		cmp_wt_0 = 4'd3,
		wb_0     = 4'd4,
		wb_1     = 4'd5,
		wb_2     = 4'd6,
		wb_3     = 4'd7,
		fill_0   = 4'd8,
		fill_1   = 4'd9,
		fill_2   = 4'd10,
		fill_3   = 4'd11,
		fill_4   = 4'd12,
		fill_5   = 4'd13,
		cmp_rd_1 = 4'd14,
		cmp_wt_1 = 4'd15
	} ctrl_state_t;

endpackage

// ==== design/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] data_in,
	input  logic              rd,
	input  logic              wr,
	output logic [DATA_W-1:0] data_out,
	output logic              done,
	output logic              cache_hit,
	output logic              stall
);

	cache_if cache_bus ();
	mem_if mem_bus ();

	cache_ctrl cache_ctrl_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.cache_hit (cache_hit),
		.stall     (stall),
		.cif       (cache_bus),
		.mif       (mem_bus)
	);

	cache_array cache_array_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.cif    (cache_bus)
	);

	banked_memory banked_memory_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.mif    (mem_bus)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
	-f verilog.f -o cache_sim \
	&& ./obj_dir/cache_sim 2>&1 | tee sim.log \
	&& grep -q "^all tests passed$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== verif/cache_assertions.sv ====
`timescale 1ns/1ps

module cache_assertions import cache_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input ctrl_state_t state,
	input logic        done,
	input logic        cache_hit,
	input logic        stall,
	input logic        arr_hit,
	input logic        arr_valid,
	input logic        arr_dirty,
	input logic        mem_rd,
	input logic        mem_wr
);

	int fail_count = 0;
	logic in_cmp;
	logic hit_seen;
	logic dirty_seen;
	logic clean_seen;

	// First compare one cycle after idle took the request
	assign in_cmp = (state == cmp_rd_0) || (state == cmp_wt_0);

	// Lookup result seen by the first compare
	assign hit_seen = in_cmp && arr_valid && arr_hit;
	assign dirty_seen = in_cmp && arr_valid && !arr_hit && arr_dirty;
	assign clean_seen = in_cmp && !(arr_valid && (arr_hit || arr_dirty));

	done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> !done)
		else
		begin
			fail_count++;
			$error("done held for more than one cycle");
		end

	hit_with_done: assert property (@(posedge clk) disable iff (!arst_n)
		cache_hit |-> done)
		else
		begin
			fail_count++;
			$error("cache_hit without done");
		end

	stall_not_idle: assert property (@(posedge clk) disable iff (!arst_n)
		stall == (state != idle))
		else
		begin
			fail_count++;
			$error("stall does not match the idle state");
		end

	// Latencies counted from the edge that samples the request
	hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
		hit_seen |=> (done && cache_hit))
		else
		begin
			fail_count++;
			$error("hit did not complete in 2 cycles");
		end

	clean_latency: assert property (@(posedge clk) disable iff (!arst_n)
		clean_seen |-> ##7 (done && !cache_hit))
		else
		begin
			fail_count++;
			$error("clean miss did not complete in 8 cycles");
		end

	dirty_latency: assert property (@(posedge clk) disable iff (!arst_n)
		dirty_seen |-> ##11 (done && !cache_hit))
		else
		begin
			fail_count++;
			$error("dirty miss did not complete in 12 cycles");
		end

	mem_rd_wr: assert property (@(posedge clk) disable iff (!arst_n)
		mem_rd |-> !mem_wr)
		else
		begin
			fail_count++;
			$error("memory read and write strobes together");
		end

endmodule

bind cache_ctrl cache_assertions cache_assertions_inst (
	.clk        (clk),
	.arst_n     (arst_n),
	.state      (state),
	.done       (done),
	.cache_hit  (cache_hit),
	.stall      (stall),
	.arr_hit    (cif.hit),
	.arr_valid  (cif.valid),
	.arr_dirty  (cif.dirty),
	.mem_rd     (mif.rd),
	.mem_wr     (mif.wr)
);

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

	logic clk = 1'b0;
	logic arst_n;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data_in;
	logic rd;
	logic wr;
	logic [DATA_W-1:0] data_out;
	logic done;
	logic cache_hit;
	logic stall;

	// Reference view of memory and of each line's state
	logic [DATA_W-1:0] shadow [MEM_WORDS];
	logic line_valid [LINES];
	logic line_dirty [LINES];
	logic [TAG_W-1:0] line_tag [LINES];

	logic [31:0] seed = 32'hca634498;
	logic hung = 1'b0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int bound_fails_seen = 0;

	cache_top cache_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.cache_hit (cache_hit),
		.stall     (stall)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		assert (actual == expected)
		else
		begin
			errors++;
			$display("FAIL %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic check_quiet();
		check_value("stall", DATA_W'(stall), '0);
		check_value("done", DATA_W'(done), '0);
		check_value("cache_hit", DATA_W'(cache_hit), '0);
	endtask

	// One host request checked against the line and memory model
	task automatic access(input logic is_wr, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0] tg;
		logic [ADDR_W-2:0] w;
		logic exp_hit;
		logic seen;
		int exp_lat;
		int cycles;

		idx = a[ADDR_W-1:ADDR_W-INDEX_W];
		tg = a[OFFSET_W+TAG_W-1:OFFSET_W];
		w = a[ADDR_W-1:1];
		exp_hit = line_valid[idx] && (line_tag[idx] == tg);
		if (exp_hit)
			exp_lat = 2;
		else if (line_valid[idx] && line_dirty[idx])
			exp_lat = 12;
		else
			exp_lat = 8;
		seen = 1'b0;
		cycles = 0;
		if (!hung)
		begin
			@(posedge clk);
			addr <= a;
			data_in <= d;
			rd <= !is_wr;
			wr <= is_wr;
			// Idle takes the request at this edge
			@(posedge clk);
			while (!seen && cycles < 40)
			begin
				@(negedge clk);
				cycles++;
				seen = done;
			end
			if (!seen)
			begin
				errors++;
				hung = 1'b1;
				$display("timeout: no done within 40 cycles for the request at address %h", a);
			end
			else
			begin
				check_value("cache_hit", DATA_W'(cache_hit), DATA_W'(exp_hit));
				if (!is_wr)
					check_value("data_out", data_out, shadow[w]);
				assert (cycles == exp_lat)
				else
				begin
					errors++;
					$display("wrong latency: done came %0d cycles after the request, not %0d",
						cycles, exp_lat);
				end
				line_valid[idx] = 1'b1;
				line_tag[idx] = tg;
				if (is_wr)
				begin
					line_dirty[idx] = 1'b1;
					shadow[w] = d;
				end
				else if (!exp_hit)
					line_dirty[idx] = 1'b0;
			end
			@(posedge clk);
			rd <= 1'b0;
			wr <= 1'b0;
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		int new_fails;

		// Bound assertion failures since the last test
		new_fails = cache_top_inst.cache_ctrl_inst.cache_assertions_inst.fail_count
			- bound_fails_seen;
		bound_fails_seen += new_fails;
		errors += new_fails;
		errs = errors - test_errors;
		tests_run++;
		if (errs == 0)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errs);
		end
		test_errors = errors;
	endtask

	initial
	begin
		int i;
		logic is_wr;
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] b;

		arst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		for (i = 0; i < MEM_WORDS; i++)
			shadow[i] = '0;
		for (i = 0; i < LINES; i++)
		begin
			line_valid[i] = 1'b0;
			line_dirty[i] = 1'b0;
			line_tag[i] = '0;
		end

		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			check_quiet();
		end
		end_test("reset_idle");

		// Cold write misses and the read back hits
		a = {8'h05, 5'd3, 2'd1, 1'b0};
		access(1'b1, a, 16'hbeef);
		access(1'b0, a, '0);
		end_test("write_read_hit");

		access(1'b0, {8'h20, 5'd9, 2'd2, 1'b0}, '0);
		end_test("cold_read_zero");

		// Same index with a different tag
		a = {8'h30, 5'd1, 2'd0, 1'b0};
		b = {8'h30, 5'd2, 2'd1, 1'b0};
		access(1'b1, a, 16'h1234);
		access(1'b1, {8'h30, 5'd1, 2'd2, 1'b0}, 16'h5a5a);
		access(1'b1, b, 16'hc0de);
		access(1'b0, a, '0);
		end_test("dirty_eviction");

		access(1'b0, {8'h30, 5'd1, 2'd1, 1'b0}, '0);
		access(1'b0, {8'h30, 5'd1, 2'd2, 1'b0}, '0);
		access(1'b0, {8'h30, 5'd1, 2'd3, 1'b0}, '0);
		// B went back to memory when A was refilled
		access(1'b0, b, '0);
		end_test("line_refill_hits");

		for (i = 0; i < 200; i++)
		begin
			seed = lcg_step(seed);
			a = {8'h60 + INDEX_W'(seed[31:16] % 3), 5'd4 + TAG_W'(seed[13:12]),
				seed[11:10], 1'b0};
			is_wr = seed[9];
			seed = lcg_step(seed);
			access(is_wr, a, seed[31:16]);
		end
		end_test("random_mix");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
design/cache_pkg.sv
design/cache_if.sv
design/cache_ctrl.sv
design/cache_array.sv
design/banked_memory.sv
design/cache_top.sv
verif/cache_assertions.sv
verif/cache_tb.sv
